//--- verilog/rv_pkg.sv
// shared widths and stage types; 4 threads, 64-bit data, imem word index is pc[10:2]
package rv_pkg;

	localparam int xlen = 64;
	localparam int num_threads = 4;
	localparam int thread_w = 2;
	localparam int imem_words = 512;
	localparam int imem_aw = 9;
	localparam int dmem_words = 256;
	localparam int dmem_aw = 8;
	localparam int thread_base_stride = 'h200;

	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_itype  = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_or,
		alu_slt
	} alu_op_e;

	typedef struct packed {
		logic reg_write;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src_imm;
		logic branch;
		logic jal;
		logic jalr;
		logic [2:0] fn3;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic [thread_w-1:0] thread;
		logic [xlen-1:0] pc;
		ctrl_t ctrl;
		logic [xlen-1:0] r0_data;
		logic [xlen-1:0] r1_data;
		logic [xlen-1:0] imm;
		logic [4:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic [thread_w-1:0] thread;
		logic [xlen-1:0] pc;
		logic reg_write;
		logic mem_write;
		logic mem_to_reg;
		logic jump;
		logic branch;
		logic [2:0] fn3;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] branch_target;
		logic equal;
		logic less;
		logic [xlen-1:0] r1_data;
		logic [4:0] rd;
	} ex_me_t;

	// writeback bus into the register file
	typedef struct packed {
		logic [thread_w-1:0] thread;
		logic [4:0] rd;
		logic we;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

//--- verilog/reg_file.sv
// 4 x 32 x 64-bit registers, index is {thread, reg}; x0 reads zero and is never written
module reg_file (
	input  logic clk,
	input  logic [rv_pkg::thread_w+4:0] r0_idx,
	input  logic [rv_pkg::thread_w+4:0] r1_idx,
	input  rv_pkg::wb_t wb,
	output logic [rv_pkg::xlen-1:0] r0_data,
	output logic [rv_pkg::xlen-1:0] r1_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [num_threads*32];

	assign r0_data = (r0_idx[4:0] == 5'd0) ? '0 : regs[r0_idx];
	assign r1_data = (r1_idx[4:0] == 5'd0) ? '0 : regs[r1_idx];

	always_ff @(posedge clk) begin
		if (wb.we && wb.rd != 5'd0)
			regs[{wb.thread, wb.rd}] <= wb.data;
	end

	// an enabled write carries a known thread, index and data
	a_wb_known: assert property (@(posedge clk)
		wb.we |-> !$isunknown({wb.thread, wb.rd, wb.data}));

endmodule

//--- verilog/thread_fetch.sv
// fetch stage; thread k owns imem words k*128..k*128+127, pc bits above 10 are ignored
module thread_fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic redirect_valid,
	input  logic [rv_pkg::thread_w-1:0] redirect_thread,
	input  logic [rv_pkg::xlen-1:0] redirect_target,
	input  logic host_imem_we,
	input  logic [rv_pkg::imem_aw-1:0] host_addr,
	input  logic [31:0] host_wdata,
	output logic [31:0] instr,
	output logic [rv_pkg::xlen-1:0] fetch_pc,
	output logic [rv_pkg::thread_w-1:0] fetch_thread
);
	import rv_pkg::*;

	logic [31:0] imem [imem_words];
	logic [xlen-1:0] pc_q [num_threads];
	logic [thread_w-1:0] cnt;

	// host load port
	always_ff @(posedge clk) begin
		if (host_imem_we)
			imem[host_addr] <= host_wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			instr <= '0;
			fetch_pc <= '0;
			fetch_thread <= '0;
			for (int t = 0; t < num_threads; t++)
				pc_q[t] <= xlen'(t * thread_base_stride);
		end else if (run) begin
			instr <= imem[pc_q[cnt][imem_aw+1:2]];
			fetch_pc <= pc_q[cnt];
			fetch_thread <= cnt;
			cnt <= cnt + 1'b1;
			// redirect from memory stage wins over the +4
			for (int t = 0; t < num_threads; t++) begin
				if (redirect_valid && redirect_thread == thread_w'(t))
					pc_q[t] <= redirect_target;
				else if (cnt == thread_w'(t))
					pc_q[t] <= pc_q[t] + 64'd4;
			end
		end
	end

	// host must leave imem alone while the pipeline runs
	a_no_host_write_in_run: assert property (
		@(posedge clk) disable iff (!rst_n) run |-> !host_imem_we);

endmodule

//--- verilog/decode_unit.sv
// decode stage; unsupported opcodes become bubbles, bit 30 selects SUB only for R-type
module decode_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic [31:0] instr,
	input  logic [rv_pkg::xlen-1:0] pc,
	input  logic [rv_pkg::thread_w-1:0] thread,
	input  rv_pkg::wb_t wb,
	output rv_pkg::id_ex_t id_ex
);
	import rv_pkg::*;

	ctrl_t ctrl;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] r0_data;
	logic [xlen-1:0] r1_data;
	logic [2:0] fn3;

	assign fn3 = instr[14:12];

	always_comb begin
		ctrl = '0;
		ctrl.fn3 = fn3;
		ctrl.alu_op = alu_add;
		case (opcode_e'(instr[6:0]))
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				if (fn3 == 3'b000 && instr[30])
					ctrl.alu_op = alu_sub;
				else if (fn3 == 3'b001)
					ctrl.alu_op = alu_sll;
				else if (fn3 == 3'b110)
					ctrl.alu_op = alu_or;
			end
			op_itype: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				if (fn3 == 3'b001)
					ctrl.alu_op = alu_sll;
				else if (fn3 == 3'b110)
					ctrl.alu_op = alu_or;
			end
			op_load: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_branch: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = alu_slt;
			end
			// jal adds pc + imm, jalr adds rs1 + imm
			op_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.jal = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_jalr: begin
				ctrl.reg_write = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		case (opcode_e'(instr[6:0]))
			op_itype, op_load, op_jalr: imm = {{52{instr[31]}}, instr[31:20]};
			op_store:  imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
			op_branch: imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			op_jal:    imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default:   imm = '0;
		endcase
	end

	reg_file u_rf (
		.clk     (clk),
		.r0_idx  ({thread, instr[19:15]}),
		.r1_idx  ({thread, instr[24:20]}),
		.wb      (wb),
		.r0_data (r0_data),
		.r1_data (r1_data)
	);

	always_ff @(posedge clk) begin
		if (!rst_n)
			id_ex <= '0;
		else if (run)
			id_ex <= '{thread: thread, pc: pc, ctrl: ctrl, r0_data: r0_data,
				r1_data: r1_data, imm: imm, rd: instr[11:7]};
	end

endmodule

//--- verilog/execute_unit.sv
// execute stage; flags compare the two ALU operands, less is signed only
module execute_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  rv_pkg::id_ex_t id_ex,
	output rv_pkg::ex_me_t ex_me
);
	import rv_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] result;
	logic equal;
	logic less;

	assign op_a = id_ex.ctrl.jal ? id_ex.pc : id_ex.r0_data;
	assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.r1_data;
	assign equal = (op_a == op_b);
	assign less = ($signed(op_a) < $signed(op_b));

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_sub: result = op_a - op_b;
			// RV64 shift amount is 6 bits
			alu_sll: result = op_a << op_b[5:0];
			alu_or:  result = op_a | op_b;
			alu_slt: result = {{(xlen-1){1'b0}}, less};
			default: result = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_me <= '0;
		end else if (run) begin
			ex_me.thread <= id_ex.thread;
			ex_me.pc <= id_ex.pc;
			ex_me.reg_write <= id_ex.ctrl.reg_write;
			ex_me.mem_write <= id_ex.ctrl.mem_write;
			ex_me.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_me.jump <= id_ex.ctrl.jal | id_ex.ctrl.jalr;
			ex_me.branch <= id_ex.ctrl.branch;
			ex_me.fn3 <= id_ex.ctrl.fn3;
			ex_me.alu_result <= result;
			ex_me.branch_target <= id_ex.pc + id_ex.imm;
			ex_me.equal <= equal;
			ex_me.less <= less;
			ex_me.r1_data <= id_ex.r1_data;
			ex_me.rd <= id_ex.rd;
		end
	end

endmodule

//--- verilog/mem_stage.sv
// memory + writeback; dmem word address is alu_result[10:3], host owns dmem while run is low
module mem_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  rv_pkg::ex_me_t ex_me,
	input  logic host_dmem_we,
	input  logic host_rd,
	input  logic [rv_pkg::dmem_aw-1:0] host_addr,
	input  logic [rv_pkg::xlen-1:0] host_wdata,
	output logic [rv_pkg::xlen-1:0] host_rdata,
	output logic redirect_valid,
	output logic [rv_pkg::thread_w-1:0] redirect_thread,
	output logic [rv_pkg::xlen-1:0] redirect_target,
	output rv_pkg::wb_t wb
);
	import rv_pkg::*;

	logic [xlen-1:0] dmem [dmem_words];
	logic [dmem_aw-1:0] addr;
	logic we;
	logic [xlen-1:0] wdata;
	logic taken;

	// writeback stage registers
	logic [thread_w-1:0] wb_thread;
	logic [4:0] wb_rd;
	logic wb_reg_write;
	logic wb_mem_to_reg;
	logic wb_jump;
	logic [xlen-1:0] wb_pc;
	logic [xlen-1:0] wb_alu;
	logic [xlen-1:0] wb_load;

	assign addr = run ? ex_me.alu_result[10:3] : host_addr;
	assign we = run ? ex_me.mem_write : host_dmem_we;
	assign wdata = run ? ex_me.r1_data : host_wdata;

	always_ff @(posedge clk) begin
		if (we)
			dmem[addr] <= wdata;
		if (run)
			wb_load <= dmem[addr];
		if (host_rd)
			host_rdata <= dmem[addr];
	end

	always_comb begin
		case (ex_me.fn3)
			3'b000:  taken = ex_me.equal;
			3'b001:  taken = ~ex_me.equal;
			3'b100:  taken = ex_me.less;
			3'b101:  taken = ~ex_me.less;
			default: taken = 1'b0;
		endcase
		taken = taken & ex_me.branch;
	end

	assign redirect_valid = ex_me.jump | taken;
	assign redirect_thread = ex_me.thread;
	assign redirect_target = ex_me.jump ? ex_me.alu_result : ex_me.branch_target;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_reg_write <= 1'b0;
			wb_mem_to_reg <= 1'b0;
			wb_jump <= 1'b0;
		end else if (run) begin
			wb_reg_write <= ex_me.reg_write;
			wb_mem_to_reg <= ex_me.mem_to_reg;
			wb_jump <= ex_me.jump;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			wb_thread <= ex_me.thread;
			wb_rd <= ex_me.rd;
			wb_pc <= ex_me.pc;
			wb_alu <= ex_me.alu_result;
		end
	end

	// link value for jumps, load data, else ALU
	assign wb.thread = wb_thread;
	assign wb.rd = wb_rd;
	assign wb.we = wb_reg_write & run;
	assign wb.data = wb_jump ? wb_pc + 64'd4 : (wb_mem_to_reg ? wb_load : wb_alu);

	a_no_host_in_run: assert property (
		@(posedge clk) disable iff (!rst_n) run |-> !(host_dmem_we || host_rd));

endmodule

//--- verilog/barrel_core.sv
// 4-thread barrel core top; host port (host_sel 0 = imem, 1 = dmem) only usable while run is low
module barrel_core (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic host_sel,
	input  logic host_we,
	input  logic host_rd,
	input  logic [8:0] host_addr,
	input  logic [63:0] host_wdata,
	output logic [63:0] host_rdata
);
	import rv_pkg::*;

	logic [31:0] instr;
	logic [xlen-1:0] fetch_pc;
	logic [thread_w-1:0] fetch_thread;
	id_ex_t id_ex;
	ex_me_t ex_me;
	wb_t wb;
	logic redirect_valid;
	logic [thread_w-1:0] redirect_thread;
	logic [xlen-1:0] redirect_target;

	// host write strobe routed to one memory
	logic host_imem_we;
	logic host_dmem_we;

	assign host_imem_we = host_we & ~host_sel;
	assign host_dmem_we = host_we & host_sel;

	thread_fetch u_fetch (
		.clk             (clk),
		.rst_n           (rst_n),
		.run             (run),
		.redirect_valid  (redirect_valid),
		.redirect_thread (redirect_thread),
		.redirect_target (redirect_target),
		.host_imem_we    (host_imem_we),
		.host_addr       (host_addr),
		.host_wdata      (host_wdata[31:0]),
		.instr           (instr),
		.fetch_pc        (fetch_pc),
		.fetch_thread    (fetch_thread)
	);

	decode_unit u_decode (
		.clk    (clk),
		.rst_n  (rst_n),
		.run    (run),
		.instr  (instr),
		.pc     (fetch_pc),
		.thread (fetch_thread),
		.wb     (wb),
		.id_ex  (id_ex)
	);

	execute_unit u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.run   (run),
		.id_ex (id_ex),
		.ex_me (ex_me)
	);

	mem_stage u_mem (
		.clk             (clk),
		.rst_n           (rst_n),
		.run             (run),
		.ex_me           (ex_me),
		.host_dmem_we    (host_dmem_we),
		.host_rd         (host_rd),
		.host_addr       (host_addr[dmem_aw-1:0]),
		.host_wdata      (host_wdata),
		.host_rdata      (host_rdata),
		.redirect_valid  (redirect_valid),
		.redirect_thread (redirect_thread),
		.redirect_target (redirect_target),
		.wb              (wb)
	);

endmodule

//--- include/tb_programs.svh
// programs for threads 0..3 at word k*128; words 0 and 1 of thread 0 carry the ADDI immediates
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int prog_len = 20;
localparam int num_exp = 5;

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
	logic [4:0] rd, logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// thread 0: ((a + b) << 4 | 0xf) - a stored at word 0, default a = 0x123, b = 0x045
localparam logic [31:0] prog [4][prog_len] = '{
	'{0: enc_i(12'h123, 0, 0, 1, 7'h13), 1: enc_i(12'h045, 0, 0, 2, 7'h13),
		2: enc_r(0, 2, 1, 0, 3), 3: enc_r(7'h20, 2, 3, 0, 4), 4: enc_i(4, 3, 1, 5, 7'h13),
		5: enc_i(12'h00f, 5, 6, 5, 7'h13), 6: enc_r(7'h20, 4, 5, 0, 5),
		7: enc_s(0, 5, 0), 8: enc_j(0, 0), default: 32'h0},
	// thread 1: ld / sd, then jal link stored at word 10
	'{0: enc_i(12'h040, 0, 3, 1, 7'h03), 1: enc_i(12'h055, 1, 0, 1, 7'h13),
		2: enc_s(12'h048, 1, 0), 3: enc_j(8, 2), 4: enc_i(0, 0, 0, 2, 7'h13),
		5: enc_s(12'h050, 2, 0), 6: enc_j(0, 0), default: 32'h0},
	// thread 2: x1 = 5, x2 = -3, not-taken paths set marker bits in x3
	'{0: enc_i(5, 0, 0, 1, 7'h13), 1: enc_i(-3, 0, 0, 2, 7'h13),
		2: enc_b(8, 2, 1, 0), 3: enc_i(12'h01, 3, 6, 3, 7'h13),
		4: enc_b(8, 1, 1, 0), 5: enc_i(12'h02, 3, 6, 3, 7'h13),
		6: enc_b(8, 1, 1, 1), 7: enc_i(12'h04, 3, 6, 3, 7'h13),
		8: enc_b(8, 2, 1, 1), 9: enc_i(12'h08, 3, 6, 3, 7'h13),
		10: enc_b(8, 1, 2, 4), 11: enc_i(12'h10, 3, 6, 3, 7'h13),
		12: enc_b(8, 2, 1, 4), 13: enc_i(12'h20, 3, 6, 3, 7'h13),
		14: enc_b(8, 2, 1, 5), 15: enc_i(12'h40, 3, 6, 3, 7'h13),
		16: enc_b(8, 1, 2, 5), 17: enc_i(12'h80, 3, 6, 3, 7'h13),
		18: enc_s(12'h060, 3, 0), 19: enc_j(0, 0)},
	// thread 3: jalr to 0x610, link stored at word 13
	'{0: enc_i(12'h610, 0, 0, 1, 7'h13), 1: enc_i(0, 1, 0, 2, 7'h67),
		2: enc_i(0, 0, 0, 2, 7'h13), 3: enc_i(0, 0, 0, 2, 7'h13),
		4: enc_s(12'h068, 2, 0), 5: enc_j(0, 0), default: 32'h0}
};

// word 8 is preloaded by the host before the run
localparam logic [63:0] dmem_preload = 64'h1122_3344_5566_7788;
localparam int exp_word [num_exp] = '{0, 8, 9, 10, 12};
localparam logic [63:0] exp_data [num_exp] = '{64'h156c, dmem_preload,
	dmem_preload + 64'h55, 64'h210, 64'ha5};
localparam int exp_jalr_word = 13;
localparam logic [63:0] exp_jalr_data = 64'h608;

`endif

//--- bench/tb_core.sv
// testbench for barrel_core; registers power up unknown, so a first program zeroes x1..x31
module tb_core;
	import rv_pkg::*;

	`include "tb_programs.svh"

	localparam int rst_cycles = 16;
	localparam int clear_words = 32;
	localparam int run_cycles = 4 * clear_words + 16;
	localparam int pat_base = 'hf0;
	localparam int pat_words = 8;
	localparam int load_cycles = num_threads * (clear_words + prog_len) + 1 + pat_words + 4;
	localparam int read_cycles = 2 * (2 * pat_words + num_exp + 1);
	localparam int total_cycles = 2 * rst_cycles + 2 * run_cycles + load_cycles + read_cycles;
	localparam int cycle_limit = 2 * total_cycles;

	logic clk;
	logic rst_n;
	logic run;
	logic host_sel;
	logic host_we;
	logic host_rd;
	logic [8:0] host_addr;
	logic [63:0] host_wdata;
	logic [63:0] host_rdata;

	int errors;
	int cycle_count;
	integer seed;
	logic [11:0] imm_a;
	logic [11:0] imm_b;
	logic [31:0] word;
	logic [63:0] rdata;
	logic [63:0] sum;
	logic [63:0] arith_expected;
	logic [63:0] expected;

	barrel_core u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.host_sel   (host_sel),
		.host_we    (host_we),
		.host_rd    (host_rd),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles, %0d errors so far",
				cycle_limit, errors);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [63:0] sign_extend(logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	// spare dmem words get a value tied to their address
	function automatic logic [63:0] fill_value(logic [7:0] a);
		return {8{a}} ^ 64'h0123_4567_89ab_cdef;
	endfunction

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (rst_cycles) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// strobe held across exactly one rising edge
	task automatic write_mem(logic sel, logic [8:0] addr, logic [63:0] data);
		@(negedge clk);
		host_sel = sel;
		host_we = 1'b1;
		host_rd = 1'b0;
		host_addr = addr;
		host_wdata = data;
	endtask

	task automatic release_host();
		@(negedge clk);
		host_we = 1'b0;
		host_rd = 1'b0;
	endtask

	task automatic read_dmem(logic [8:0] addr, output logic [63:0] data);
		@(negedge clk);
		host_sel = 1'b1;
		host_we = 1'b0;
		host_rd = 1'b1;
		host_addr = addr;
		@(negedge clk);
		host_rd = 1'b0;
		data = host_rdata;
	endtask

	task automatic run_window(int cycles);
		@(negedge clk);
		run = 1'b1;
		repeat (cycles) @(negedge clk);
		run = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		host_sel = 1'b0;
		host_we = 1'b0;
		host_rd = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		errors = 0;
		cycle_count = 0;
		seed = 5;
		pulse_reset();

		// host round trip on spare data words
		for (int i = 0; i < pat_words; i++)
			write_mem(1'b1, 9'(pat_base + i), fill_value(8'(pat_base + i)));
		release_host();
		for (int i = 0; i < pat_words; i++) begin
			read_dmem(9'(pat_base + i), rdata);
			check_value($sformatf("host_rdata[%0d]", pat_base + i), rdata,
				fill_value(8'(pat_base + i)));
		end

		// zero x1..x31 of every thread, then park on a self loop
		for (int t = 0; t < num_threads; t++)
			for (int i = 0; i < clear_words; i++)
				write_mem(1'b0, 9'(t * 128 + i), (i < clear_words - 1) ?
					64'(enc_i(0, 0, 0, 5'(i + 1), 7'h13)) : 64'(enc_j(0, 0)));
		release_host();
		run_window(run_cycles);

		imm_a = 12'($random(seed));
		imm_b = 12'($random(seed));
		for (int t = 0; t < num_threads; t++) begin
			for (int i = 0; i < prog_len; i++) begin
				word = prog[t][i];
				if (t == 0 && i == 0)
					word = enc_i(imm_a, 0, 0, 1, 7'h13);
				else if (t == 0 && i == 1)
					word = enc_i(imm_b, 0, 0, 2, 7'h13);
				write_mem(1'b0, 9'(t * 128 + i), 64'(word));
			end
		end
		write_mem(1'b1, 9'd8, dmem_preload);
		release_host();
		pulse_reset();
		run_window(run_cycles);

		// add, sub back out b, shift by 4, or in 0xf, subtract a
		sum = sign_extend(imm_a) + sign_extend(imm_b);
		arith_expected = ((sum << 4) | 64'hf) - (sum - sign_extend(imm_b));
		for (int k = 0; k < num_exp; k++) begin
			expected = (k == 0) ? arith_expected : exp_data[k];
			read_dmem(9'(exp_word[k]), rdata);
			check_value($sformatf("dmem[%0d]", exp_word[k]), rdata, expected);
		end
		read_dmem(9'(exp_jalr_word), rdata);
		check_value($sformatf("dmem[%0d]", exp_jalr_word), rdata, exp_jalr_data);

		// spare words untouched by the programs
		for (int i = 0; i < pat_words; i++) begin
			read_dmem(9'(pat_base + i), rdata);
			check_value($sformatf("dmem[%0d]", pat_base + i), rdata,
				fill_value(8'(pat_base + i)));
		end

		$display("checks done: %0d errors in %0d cycles", errors, cycle_count);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/thread_fetch.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_stage.sv
verilog/barrel_core.sv
bench/tb_core.sv
